//--- Bender.yml
package:
  name: word_gen

sources:
  - word_gen_pkg.sv
  - word_gen_ram.sv
  - word_list.sv
  - word_storage.sv
  - word_gen.sv
  - word_gen_top.sv
  - target: test
    files:
      - word_gen_tb.sv

//--- src.f
word_gen_pkg.sv
word_gen_ram.sv
word_list.sv
word_storage.sv
word_gen.sv
word_gen_top.sv
word_gen_tb.sv

//--- word_gen.sv
`timescale 1ns/1ps

module word_gen #(
	parameter int RANGES_MAX = 3
) (
	input  logic                                        CLK,
	input  logic                                        arst_n,
	// Configuration
	input  word_gen_pkg::byte_t                         din,
	input  word_gen_pkg::id_t                           inpkt_id,
	input  logic                                        conf_wr_en,
	output logic                                        conf_full,
	// Word list
	input  word_gen_pkg::byte_t                         word_in,
	output word_gen_pkg::word_addr_t                    word_rd_addr,
	input  logic                                        word_empty,
	input  logic                                        word_list_end,
	output logic                                        word_set_empty,
	input  word_gen_pkg::range_info_t [RANGES_MAX-1:0] range_info,
	// Word storage
	output word_gen_pkg::byte_t                         storage_din,
	output word_gen_pkg::word_addr_t                    storage_wr_addr,
	output logic                                        storage_wr_en,
	output logic                                        storage_set_full,
	input  logic                                        storage_full,
	// Range character RAM
	output logic [$clog2(RANGES_MAX)+7:0]               ram_addr,
	output logic                                        ram_en,
	output logic                                        ram_wr_en,
	input  word_gen_pkg::byte_t                         ram_dout,
	// Candidate side data
	output word_gen_pkg::id_t                           pkt_id,
	output logic [31:0]                                 gen_id,
	output logic                                        word_end,
	output logic                                        err_word_gen_conf
);
	import word_gen_pkg::*;

	localparam int RNG_W = $clog2(RANGES_MAX);

	gen_state_e state;

	// Range being configured or substituted
	logic [RNG_W-1:0] cur_range;
	// Number of the last range
	logic [RNG_W-1:0] last_range_num;
	logic             zero_ranges;

	// Char index and its limit for cur_range
	byte_t cur_count;
	byte_t cur_count_max;
	// Odometer carry into cur_range
	logic  range_carry;

	// Four unused num_generate bytes
	logic [1:0] conf_num_generate;

	byte_t       din_minus_1;
	range_info_t cur_info;

	// Small distributed arrays, one entry per range
	byte_t range_counter   [RANGES_MAX];
	byte_t range_count_max [RANGES_MAX];

	assign din_minus_1 = din - 8'd1;
	assign cur_info = range_info[cur_range];

	// ********************
	// Main FSM
	// ********************

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			state <= CONF_NUM_RANGES;
			conf_full <= 1'b0;
			cur_range <= '0;
			last_range_num <= '0;
			zero_ranges <= 1'b1;
			cur_count <= '0;
			cur_count_max <= '0;
			range_carry <= 1'b1;
			conf_num_generate <= '0;
			word_rd_addr <= '0;
			storage_wr_addr <= '0;
			pkt_id <= '0;
			gen_id <= '0;
			word_end <= 1'b0;
		end else begin
			case (state)
			CONF_NUM_RANGES: if (conf_wr_en) begin
				pkt_id <= inpkt_id;
				last_range_num <= din_minus_1[RNG_W-1:0];
				cur_range <= '0;
				zero_ranges <= (din == 8'd0);
				// Too many ranges for this build
				if (din > byte_t'(RANGES_MAX)) begin
					state <= CONF_ERROR;
				end else if (din != 8'd0) begin
					state <= CONF_RANGE_NUM_CHARS;
				end else begin
					state <= CONF_NUM_GENERATE;
				end
			end
			CONF_RANGE_NUM_CHARS: if (conf_wr_en) begin
				// Zero chars wraps to 256
				cur_count_max <= din_minus_1;
				cur_count <= '0;
				state <= CONF_RANGE_START_IDX;
			end
			CONF_RANGE_START_IDX: if (conf_wr_en) begin
				state <= CONF_RANGE_CHARS;
			end
			CONF_RANGE_CHARS: if (conf_wr_en) begin
				cur_count <= cur_count + 8'd1;
				if (cur_count == cur_count_max) begin
					cur_range <= cur_range + 1'b1;
					if (cur_range == last_range_num) begin
						state <= CONF_NUM_GENERATE;
					end else begin
						state <= CONF_RANGE_NUM_CHARS;
					end
				end
			end
			CONF_NUM_GENERATE: if (conf_wr_en) begin
				conf_num_generate <= conf_num_generate + 1'b1;
				if (conf_num_generate == 2'd3) begin
					state <= CONF_MAGIC;
				end
			end
			CONF_MAGIC: if (conf_wr_en) begin
				cur_range <= '0;
				if (din == CONF_MAGIC_BYTE) begin
					conf_full <= 1'b1;
					state <= OP_RESET;
				end else begin
					state <= CONF_ERROR;
				end
			end
			// Held until reset
			CONF_ERROR: begin
				state <= CONF_ERROR;
			end
			// Clear one range counter per cycle
			OP_RESET: begin
				word_rd_addr <= '0;
				storage_wr_addr <= '0;
				cur_range <= cur_range + 1'b1;
				if (cur_range == RNG_W'(RANGES_MAX - 1)) begin
					state <= OP_COPY_NEXT_WORD;
				end
			end
			// Template into storage, one byte per cycle
			OP_COPY_NEXT_WORD: if (!word_empty) begin
				word_rd_addr <= word_rd_addr + 1'b1;
				storage_wr_addr <= storage_wr_addr + 1'b1;
				cur_range <= last_range_num;
				range_carry <= 1'b1;
				gen_id <= '0;
				word_end <= 1'b1;
				if (storage_wr_addr == word_addr_t'(WORD_MAX_LEN - 1)) begin
					if (zero_ranges || word_list_end) begin
						state <= OP_WAIT_READ;
					end else begin
						state <= OP_NEXT_RANGE_1;
					end
				end
			end
			OP_NEXT_RANGE_1: begin
				cur_count <= range_counter[cur_range];
				cur_count_max <= range_count_max[cur_range];
				state <= OP_NEXT_RANGE_2;
			end
			// RAM read issued here, carry ripples on
			OP_NEXT_RANGE_2: begin
				if (range_carry && cur_info.active) begin
					range_carry <= (cur_count == cur_count_max);
				end
				storage_wr_addr <= cur_info.pos;
				state <= OP_NEXT_RANGE_WR;
			end
			OP_NEXT_RANGE_WR: begin
				cur_range <= cur_range - 1'b1;
				if (cur_range == '0) begin
					// Carry out of range 0 means last combination
					word_end <= range_carry;
					state <= OP_WAIT_READ;
				end else begin
					state <= OP_NEXT_RANGE_1;
				end
			end
			// Candidate sits in storage until read
			OP_WAIT_READ: if (!storage_full) begin
				gen_id <= gen_id + 32'd1;
				if (word_list_end) begin
					cur_range <= '0;
					conf_full <= 1'b0;
					state <= CONF_NUM_RANGES;
				end else if (range_carry) begin
					cur_range <= '0;
					state <= OP_RESET;
				end else begin
					range_carry <= 1'b1;
					cur_range <= last_range_num;
					state <= OP_NEXT_RANGE_1;
				end
			end
			default: state <= CONF_ERROR;
			endcase
		end
	end

	// ********************
	// Range tables
	// ********************

	always_ff @(posedge CLK) begin
		if (state == CONF_RANGE_START_IDX && conf_wr_en) begin
			range_count_max[cur_range] <= cur_count_max;
		end
		if (state == OP_RESET) begin
			range_counter[cur_range] <= '0;
		end else if (state == OP_NEXT_RANGE_2 && range_carry && cur_info.active) begin
			range_counter[cur_range] <= (cur_count == cur_count_max) ? 8'd0 : cur_count + 8'd1;
		end
	end

	// RAM written while parsing, read while substituting
	assign ram_wr_en = (state == CONF_RANGE_CHARS) && conf_wr_en;
	assign ram_en = ram_wr_en || state == OP_NEXT_RANGE_2;
	assign ram_addr = {cur_range, cur_count};

	// Storage writes
	assign storage_wr_en = (state == OP_COPY_NEXT_WORD && !word_empty)
		|| (state == OP_NEXT_RANGE_WR && cur_info.active);
	assign storage_din = (state == OP_COPY_NEXT_WORD) ? word_in : ram_dout;
	assign storage_set_full = (state == OP_NEXT_RANGE_WR && cur_range == '0)
		|| (state == OP_COPY_NEXT_WORD && !word_empty && (zero_ranges || word_list_end)
			&& storage_wr_addr == word_addr_t'(WORD_MAX_LEN - 1));

	// Word released after its last candidate is read
	assign word_set_empty = state == OP_WAIT_READ && !storage_full
		&& (range_carry || word_list_end);

	assign err_word_gen_conf = (state == CONF_ERROR);

	assert property (@(posedge CLK) disable iff (!arst_n)
		!$isunknown(state) && state inside {CONF_NUM_RANGES, CONF_RANGE_NUM_CHARS,
			CONF_RANGE_START_IDX, CONF_RANGE_CHARS, CONF_NUM_GENERATE, CONF_MAGIC,
			CONF_ERROR, OP_RESET, OP_COPY_NEXT_WORD, OP_NEXT_RANGE_1, OP_NEXT_RANGE_2,
			OP_NEXT_RANGE_WR, OP_WAIT_READ});

	// Candidate in storage is never overwritten
	assert property (@(posedge CLK) disable iff (!arst_n)
		storage_wr_en |-> !storage_full);

endmodule

//--- word_gen_pkg.sv
package word_gen_pkg;

	// ********************
	// Word geometry
	// ********************

	// Every word and every candidate is this many bytes long
	localparam int WORD_MAX_LEN = 8;

	// Byte index within a word
	typedef logic [2:0] word_addr_t;

	// Character or configuration byte
	typedef logic [7:0] byte_t;

	// Word ID or packet ID
	typedef logic [15:0] id_t;

	// Per-range substitution info that comes with each template word
	typedef struct packed {
		logic       active;
		word_addr_t pos;
	} range_info_t;

	// Last byte of a valid configuration
	localparam byte_t CONF_MAGIC_BYTE = 8'hBB;

	// ********************
	// Generator FSM
	// ********************

	typedef enum logic [3:0] {
		CONF_NUM_RANGES,
		CONF_RANGE_NUM_CHARS,
		CONF_RANGE_START_IDX,
		CONF_RANGE_CHARS,
		CONF_NUM_GENERATE,
		CONF_MAGIC,
		CONF_ERROR,
		OP_RESET,
		OP_COPY_NEXT_WORD,
		OP_NEXT_RANGE_1,
		OP_NEXT_RANGE_2,
		OP_NEXT_RANGE_WR,
		OP_WAIT_READ
	} gen_state_e;

endpackage

//--- word_gen_ram.sv
`timescale 1ns/1ps

module word_gen_ram #(
	parameter int RANGES_MAX = 3
) (
	input  logic                          CLK,
	input  logic                          en,
	input  logic                          wr_en,
	input  logic [$clog2(RANGES_MAX)+7:0] addr,
	input  word_gen_pkg::byte_t           din,
	output word_gen_pkg::byte_t           dout
);
	import word_gen_pkg::*;

	// Characters of all ranges
	// range number sits in the upper address bits, char index in the low byte
	byte_t mem [256*RANGES_MAX];

	// Single port, one access per enabled cycle
	always_ff @(posedge CLK) begin
		if (en) begin
			if (wr_en) begin
				mem[addr] <= din;
			end else begin
				// Registered read, data valid next cycle
				dout <= mem[addr];
			end
		end
	end

endmodule

//--- word_gen_tb.sv
`timescale 1ns/1ps

module word_gen_tb;
	import word_gen_pkg::*;

	localparam int RANGES_MAX = 3;

	// ********************
	// DUT signals
	// ********************

	logic                          CLK;
	logic                          arst_n;
	byte_t                         din;
	id_t                           inpkt_id;
	logic                          conf_wr_en;
	logic                          conf_full;
	logic                          word_wr_en;
	byte_t                         word_din;
	logic                          word_commit;
	id_t                           word_id_in;
	range_info_t [RANGES_MAX-1:0] range_info_in;
	logic                          list_end_in;
	logic                          word_full;
	word_addr_t                    rd_addr;
	byte_t                         dout;
	logic                          set_empty;
	logic                          empty;
	id_t                           pkt_id;
	id_t                           word_id_out;
	logic [31:0]                   gen_id;
	logic                          word_end;
	logic                          gen_end;
	logic                          err_word_gen_conf;

	// ********************
	// Run state
	// ********************

	int               fd;
	int               rc;
	int               idx;
	int               count;
	int               num_records;
	int               cycle_count = 0;
	int               cycle_limit = 1000;
	int unsigned      lcg_state = 96355;
	logic [63:0]      tok;
	logic [8*256-1:0] line;
	logic [31:0]      val;
	logic [31:0]      id_v;
	logic [31:0]      info_v;
	logic [31:0]      pkt_v;
	int               gen_v;
	int               we_v;
	int               ge_v;
	id_t              pid;

	// Bytes of the word to write and of the expected candidate
	byte_t wr_bytes  [WORD_MAX_LEN];
	byte_t exp_bytes [WORD_MAX_LEN];

	word_gen_top #(.RANGES_MAX(RANGES_MAX)) word_gen_top_inst (
		.CLK(CLK), .arst_n(arst_n),
		.din(din), .inpkt_id(inpkt_id), .conf_wr_en(conf_wr_en), .conf_full(conf_full),
		.word_wr_en(word_wr_en), .word_din(word_din), .word_commit(word_commit),
		.word_id_in(word_id_in), .range_info_in(range_info_in), .list_end_in(list_end_in),
		.word_full(word_full),
		.rd_addr(rd_addr), .dout(dout), .set_empty(set_empty), .empty(empty),
		.pkt_id(pkt_id), .word_id_out(word_id_out), .gen_id(gen_id), .word_end(word_end),
		.gen_end(gen_end), .err_word_gen_conf(err_word_gen_conf)
	);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	// Run limit
	always @(posedge CLK) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("Run timed out after %0d cycles", cycle_count);
			fail_run();
		end
	end

	// ********************
	// Helpers
	// ********************

	task automatic fail_run();
		$display("Regression failed");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("Mismatch at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
			fail_run();
		end
	endtask

	task automatic expect_fields(input int got, input int want);
		if (got != want) begin
			$display("Test data record %0d is malformed", idx);
			fail_run();
		end
	endtask

	// LCG with the upper half of the state as output
	function automatic int unsigned next_random();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state >> 16;
	endfunction

	// One config byte with the strobe held for one cycle
	task automatic send_conf(input byte_t b, input id_t id);
		@(posedge CLK);
		din <= b;
		inpkt_id <= id;
		conf_wr_en <= 1'b1;
		@(posedge CLK);
		conf_wr_en <= 1'b0;
	endtask

	task automatic send_word(input id_t id, input logic [11:0] info, input logic list_end,
		input int len);
		int k;
		// Previous word must be released first
		@(negedge CLK);
		while (word_full) @(negedge CLK);
		for (k = 0; k < len; k++) begin
			@(posedge CLK);
			word_wr_en <= 1'b1;
			word_din <= wr_bytes[k];
		end
		// Side data latched by the commit pulse
		@(posedge CLK);
		word_wr_en <= 1'b0;
		word_commit <= 1'b1;
		word_id_in <= id;
		range_info_in <= info;
		list_end_in <= list_end;
		@(posedge CLK);
		word_commit <= 1'b0;
	endtask

	task automatic read_candidate(input id_t exp_id, input int exp_gen,
		input logic exp_word_end, input logic exp_gen_end, input id_t exp_pkt);
		int delay;
		int k;
		int n;
		@(negedge CLK);
		while (empty) @(negedge CLK);
		// Reader back-pressure of 0 to 7 cycles
		delay = next_random() % 8;
		repeat (delay) @(posedge CLK);
		@(negedge CLK);
		check_value("empty", empty, 1'b0);
		check_value("word_id_out", word_id_out, exp_id);
		check_value("gen_id", gen_id, exp_gen);
		check_value("word_end", word_end, exp_word_end);
		check_value("gen_end", gen_end, exp_gen_end);
		check_value("pkt_id", pkt_id, exp_pkt);
		// Generator stays out of configuration while a candidate waits
		check_value("conf_full", conf_full, 1'b1);
		// Registered read with dout one cycle after rd_addr
		for (k = 0; k < WORD_MAX_LEN; k++) begin
			@(posedge CLK);
			rd_addr <= word_addr_t'(k);
			@(posedge CLK);
			@(negedge CLK);
			check_value($sformatf("dout[%0d]", k), dout, exp_bytes[k]);
		end
		@(posedge CLK);
		set_empty <= 1'b1;
		@(posedge CLK);
		set_empty <= 1'b0;
		// End of list hands the generator back to configuration
		if (exp_gen_end) begin
			n = 0;
			@(negedge CLK);
			while (conf_full && n < 4) begin
				@(negedge CLK);
				n++;
			end
			if (conf_full) begin
				$display("conf_full still high at %0t after the list end candidate", $time);
				fail_run();
			end
		end
	endtask

	// Error must hold with conf_full low
	task automatic expect_error();
		int k;
		for (k = 0; k < 8; k++) begin
			@(negedge CLK);
			check_value("err_word_gen_conf", err_word_gen_conf, 1'b1);
			check_value("conf_full", conf_full, 1'b0);
		end
	endtask

	task automatic apply_reset();
		@(posedge CLK);
		arst_n <= 1'b0;
		conf_wr_en <= 1'b0;
		word_wr_en <= 1'b0;
		word_commit <= 1'b0;
		set_empty <= 1'b0;
		repeat (2) @(posedge CLK);
		arst_n <= 1'b1;
		// Values right after reset
		@(negedge CLK);
		check_value("err_word_gen_conf", err_word_gen_conf, 1'b0);
		check_value("conf_full", conf_full, 1'b0);
		check_value("empty", empty, 1'b1);
		check_value("word_full", word_full, 1'b0);
		check_value("gen_id", gen_id, 32'd0);
	endtask

	// ********************
	// Main sequence
	// ********************

	initial begin
		arst_n = 1'b0;
		din = '0;
		inpkt_id = '0;
		conf_wr_en = 1'b0;
		word_wr_en = 1'b0;
		word_din = '0;
		word_commit = 1'b0;
		word_id_in = '0;
		range_info_in = '0;
		list_end_in = 1'b0;
		rd_addr = '0;
		set_empty = 1'b0;
		idx = 0;

		// First pass only counts records
		fd = $fopen("word_gen_testdata.txt", "r");
		if (fd == 0) begin
			$display("Cannot open word_gen_testdata.txt");
			fail_run();
		end
		num_records = 0;
		while ($fscanf(fd, "%s", tok) == 1) begin
			rc = $fgets(line, fd);
			if (tok != "#") begin
				num_records++;
			end
		end
		$fclose(fd);
		cycle_limit = 40 * num_records + 1000;

		repeat (2) @(posedge CLK);
		arst_n <= 1'b1;

		fd = $fopen("word_gen_testdata.txt", "r");
		while ($fscanf(fd, "%s", tok) == 1) begin
			if (tok == "#") begin
				rc = $fgets(line, fd);
			end else if (tok == "C") begin
				idx++;
				rc = $fscanf(fd, "%h %d", pkt_v, count);
				expect_fields(rc, 2);
				pid = pkt_v[15:0];
				for (int i = 0; i < count; i++) begin
					rc = $fscanf(fd, "%h", val);
					expect_fields(rc, 1);
					// Only the range count byte carries the real packet ID
					send_conf(val[7:0], (i == 0) ? pid : ~pid);
				end
			end else if (tok == "W") begin
				idx++;
				rc = $fscanf(fd, "%h %h %d %d", id_v, info_v, ge_v, count);
				expect_fields(rc, 4);
				expect_fields(int'(count >= 1 && count <= WORD_MAX_LEN), 1);
				for (int i = 0; i < count; i++) begin
					rc = $fscanf(fd, "%h", val);
					expect_fields(rc, 1);
					wr_bytes[i] = val[7:0];
				end
				send_word(id_v[15:0], info_v[11:0], ge_v[0], count);
			end else if (tok == "E") begin
				idx++;
				for (int i = 0; i < WORD_MAX_LEN; i++) begin
					rc = $fscanf(fd, "%h", val);
					expect_fields(rc, 1);
					exp_bytes[i] = val[7:0];
				end
				rc = $fscanf(fd, "%h %d %d %d %h", id_v, gen_v, we_v, ge_v, pkt_v);
				expect_fields(rc, 5);
				read_candidate(id_v[15:0], gen_v, we_v[0], ge_v[0], pkt_v[15:0]);
			end else if (tok == "R") begin
				idx++;
				apply_reset();
			end else if (tok == "X") begin
				idx++;
				expect_error();
			end else begin
				$display("Unknown record type in test data after record %0d", idx);
				fail_run();
			end
		end
		$fclose(fd);

		// Nothing left over after the last expected candidate
		repeat (30) begin
			@(negedge CLK);
			check_value("empty", empty, 1'b1);
		end
		$display("Regression passed");
		$finish;
	end

endmodule

//--- word_gen_testdata.txt
# C pkt_id nbytes bytes | W word_id range_info list_end nbytes bytes | R reset | X conf error
# E byte0..byte7 word_id gen_id word_end gen_end pkt_id (ids and bytes hex, rest decimal)
C 0011 6 00 00 00 00 00 BB
W 0101 000 0 5 70 61 73 73 31
E 70 61 73 73 31 00 00 00 0101 0 1 0 0011
W 0102 00A 0 8 41 42 43 44 45 46 47 48
E 41 42 43 44 45 46 47 48 0102 0 1 0 0011
W 01FF 000 1 1 2E
E 2E 00 00 00 00 00 00 00 01FF 0 1 1 0011
C 0022 11 01 03 00 61 62 63 00 00 00 00 BB
W 0201 00A 0 4 6B 65 79 21
E 6B 65 61 21 00 00 00 00 0201 0 0 0 0022
E 6B 65 62 21 00 00 00 00 0201 1 0 0 0022
E 6B 65 63 21 00 00 00 00 0201 2 1 0 0022
W 02FF 00A 1 3 45 4E 44
E 45 4E 44 00 00 00 00 00 02FF 0 1 1 0022
C 0033 19 03 02 00 78 79 02 00 41 42 03 00 30 31 32 00 00 00 00 BB
W 0301 D38 0 6 5F 6D 6E 6F 70 71
E 78 6D 6E 6F 70 30 00 00 0301 0 0 0 0033
E 78 6D 6E 6F 70 31 00 00 0301 1 0 0 0033
E 78 6D 6E 6F 70 32 00 00 0301 2 0 0 0033
E 79 6D 6E 6F 70 30 00 00 0301 3 0 0 0033
E 79 6D 6E 6F 70 31 00 00 0301 4 0 0 0033
E 79 6D 6E 6F 70 32 00 00 0301 5 1 0 0033
W 03FF 000 1 1 21
E 21 00 00 00 00 00 00 00 03FF 0 1 1 0033
C 0044 6 00 00 00 00 00 AA
X
R
C 0055 1 04
X
R
C 0066 10 01 02 00 51 52 00 00 00 00 BB
W 0601 00F 0 8 61 62 63 64 65 66 67 68
E 61 62 63 64 65 66 67 51 0601 0 0 0 0066
E 61 62 63 64 65 66 67 52 0601 1 1 0 0066

//--- word_gen_top.sv
`timescale 1ns/1ps

module word_gen_top #(
	parameter int RANGES_MAX = 3
) (
	input  logic                                        CLK,
	input  logic                                        arst_n,
	// Configuration
	input  word_gen_pkg::byte_t                         din,
	input  word_gen_pkg::id_t                           inpkt_id,
	input  logic                                        conf_wr_en,
	output logic                                        conf_full,
	// Host word input
	input  logic                                        word_wr_en,
	input  word_gen_pkg::byte_t                         word_din,
	input  logic                                        word_commit,
	input  word_gen_pkg::id_t                           word_id_in,
	input  word_gen_pkg::range_info_t [RANGES_MAX-1:0] range_info_in,
	input  logic                                        list_end_in,
	output logic                                        word_full,
	// Reader
	input  word_gen_pkg::word_addr_t                    rd_addr,
	output word_gen_pkg::byte_t                         dout,
	input  logic                                        set_empty,
	output logic                                        empty,
	output word_gen_pkg::id_t                           pkt_id,
	output word_gen_pkg::id_t                           word_id_out,
	output logic [31:0]                                 gen_id,
	output logic                                        word_end,
	output logic                                        gen_end,
	output logic                                        err_word_gen_conf
);
	import word_gen_pkg::*;

	// Word list to generator
	byte_t                         word_in;
	word_addr_t                    word_rd_addr;
	logic                          word_empty;
	logic                          word_set_empty;
	range_info_t [RANGES_MAX-1:0] range_info;

	// Generator to storage
	byte_t      storage_din;
	word_addr_t storage_wr_addr;
	logic       storage_wr_en;
	logic       storage_set_full;
	logic       storage_full;

	// Generator to RAM
	logic [$clog2(RANGES_MAX)+7:0] ram_addr;
	logic                          ram_en;
	logic                          ram_wr_en;
	byte_t                         ram_dout;

	word_list #(.RANGES_MAX(RANGES_MAX)) word_list_inst (
		.CLK(CLK), .arst_n(arst_n),
		.word_wr_en(word_wr_en), .word_din(word_din), .word_commit(word_commit),
		.word_id_in(word_id_in), .range_info_in(range_info_in), .list_end_in(list_end_in),
		.word_full(word_full), .word_empty(word_empty), .word_set_empty(word_set_empty),
		.word_rd_addr(word_rd_addr), .word_in(word_in), .word_id(word_id_out),
		.range_info(range_info), .word_list_end(gen_end)
	);

	word_gen #(.RANGES_MAX(RANGES_MAX)) word_gen_inst (
		.CLK(CLK), .arst_n(arst_n),
		.din(din), .inpkt_id(inpkt_id), .conf_wr_en(conf_wr_en), .conf_full(conf_full),
		.word_in(word_in), .word_rd_addr(word_rd_addr), .word_empty(word_empty),
		.word_list_end(gen_end), .word_set_empty(word_set_empty), .range_info(range_info),
		.storage_din(storage_din), .storage_wr_addr(storage_wr_addr),
		.storage_wr_en(storage_wr_en), .storage_set_full(storage_set_full),
		.storage_full(storage_full),
		.ram_addr(ram_addr), .ram_en(ram_en), .ram_wr_en(ram_wr_en), .ram_dout(ram_dout),
		.pkt_id(pkt_id), .gen_id(gen_id), .word_end(word_end),
		.err_word_gen_conf(err_word_gen_conf)
	);

	// Range chars come straight from the configuration byte
	word_gen_ram #(.RANGES_MAX(RANGES_MAX)) word_gen_ram_inst (
		.CLK(CLK), .en(ram_en), .wr_en(ram_wr_en), .addr(ram_addr),
		.din(din), .dout(ram_dout)
	);

	word_storage word_storage_inst (
		.CLK(CLK), .arst_n(arst_n),
		.wr_en(storage_wr_en), .wr_addr(storage_wr_addr), .din(storage_din),
		.set_full(storage_set_full), .full(storage_full),
		.rd_addr(rd_addr), .dout(dout), .set_empty(set_empty), .empty(empty)
	);

endmodule

//--- word_list.sv
`timescale 1ns/1ps

module word_list #(
	parameter int RANGES_MAX = 3
) (
	input  logic                                        CLK,
	input  logic                                        arst_n,
	// Host side
	input  logic                                        word_wr_en,
	input  word_gen_pkg::byte_t                         word_din,
	input  logic                                        word_commit,
	input  word_gen_pkg::id_t                           word_id_in,
	input  word_gen_pkg::range_info_t [RANGES_MAX-1:0] range_info_in,
	input  logic                                        list_end_in,
	output logic                                        word_full,
	// Generator side
	output logic                                        word_empty,
	input  logic                                        word_set_empty,
	input  word_gen_pkg::word_addr_t                    word_rd_addr,
	output word_gen_pkg::byte_t                         word_in,
	output word_gen_pkg::id_t                           word_id,
	output word_gen_pkg::range_info_t [RANGES_MAX-1:0] range_info,
	output logic                                        word_list_end
);
	import word_gen_pkg::*;

	// Template bytes
	byte_t mem [WORD_MAX_LEN];

	// Bytes written so far, and the length latched on commit
	logic [$clog2(WORD_MAX_LEN):0] wr_cnt;
	logic [$clog2(WORD_MAX_LEN):0] word_len;

	logic wr_ok;
	logic commit_ok;

	// Host traffic is dropped while the word is held
	assign wr_ok = word_wr_en && !word_full && wr_cnt != WORD_MAX_LEN;
	assign commit_ok = word_commit && !word_full;

	always_ff @(posedge CLK) begin
		if (wr_ok && !commit_ok) begin
			mem[wr_cnt[$clog2(WORD_MAX_LEN)-1:0]] <= word_din;
		end
		// Side data of the word
		if (commit_ok) begin
			word_id <= word_id_in;
			range_info <= range_info_in;
		end
	end

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			wr_cnt <= '0;
			word_len <= '0;
			word_full <= 1'b0;
			word_list_end <= 1'b0;
		end else if (commit_ok) begin
			// Pointer restarts for the next word
			word_len <= wr_cnt;
			wr_cnt <= '0;
			word_list_end <= list_end_in;
			word_full <= 1'b1;
		end else begin
			if (wr_ok) begin
				wr_cnt <= wr_cnt + 1'b1;
			end
			if (word_set_empty) begin
				word_full <= 1'b0;
			end
		end
	end

	assign word_empty = ~word_full;

	// Bytes past the written length read as zero
	assign word_in = ({1'b0, word_rd_addr} < word_len) ? mem[word_rd_addr] : '0;

	// Host must wait for the generator to release the word
	assert property (@(posedge CLK) disable iff (!arst_n)
		word_full |-> !word_wr_en);

endmodule

//--- word_storage.sv
`timescale 1ns/1ps

module word_storage (
	input  logic                     CLK,
	input  logic                     arst_n,
	// Generator side
	input  logic                     wr_en,
	input  word_gen_pkg::word_addr_t wr_addr,
	input  word_gen_pkg::byte_t      din,
	input  logic                     set_full,
	output logic                     full,
	// Reader side
	input  word_gen_pkg::word_addr_t rd_addr,
	output word_gen_pkg::byte_t      dout,
	input  logic                     set_empty,
	output logic                     empty
);
	import word_gen_pkg::*;

	// One candidate
	byte_t mem [WORD_MAX_LEN];

	always_ff @(posedge CLK) begin
		if (wr_en) begin
			mem[wr_addr] <= din;
		end
		// Registered read port
		dout <= mem[rd_addr];
	end

	// ********************
	// Full/empty flag
	// ********************

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			full <= 1'b0;
		end else if (set_full) begin
			full <= 1'b1;
		end else if (set_empty) begin
			full <= 1'b0;
		end
	end

	assign empty = ~full;

	// Generator must not overwrite a candidate the reader still holds
	assert property (@(posedge CLK) disable iff (!arst_n)
		full |-> !wr_en);

	// Reader only releases a candidate it was given
	assert property (@(posedge CLK) disable iff (!arst_n)
		set_empty |-> full);

endmodule
